//--- common/mem_pkg.sv
`default_nettype none

// ==============================
// Memory request format
// ==============================

// Layout of a single request travelling through the memory stage, as the
// queue, the forwarders and the arbiter all see it
package mem_pkg;

	// Operation carried by a request
	// MR_LOAD sign-extends the loaded value and MR_LOADZ zero-extends it
	typedef enum logic [1:0] {
		MR_LOAD  = 2'd0,
		MR_LOADZ = 2'd1,
		MR_STORE = 2'd2
	} mem_func;

	// Access size, encoded as the log2 of the byte count
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} mem_size;

	// One request as it sits in the queue
	// For a store the data is right-justified in dat
	// For a load taken from the queue the dat field carries nothing useful
	typedef struct packed {
		logic [7:0]  tid;
		mem_func     func;
		mem_size     sz;
		logic [31:0] adr;
		logic [63:0] dat;
	} mem_request;

	// The last-tid register starts here after reset
	// No real transaction is expected to use this id
	localparam logic [7:0] TID_NONE = 8'd255;

endpackage

`default_nettype wire

//--- common/lane_pkg.sv
`default_nettype none

// ==============================
// Byte lanes of a cache line
// ==============================

// Geometry of a 16-byte line and the helpers that turn a size and an
// offset into byte selects and data masks
package lane_pkg;

	// Bytes in one line and the width of the offset inside it
	localparam int LINE_BYTES = 16;
	localparam int LANE_BITS  = 4;

	// Byte select of an access inside the line
	// Requests are naturally aligned, so the shifted select never spills out
	function automatic logic [LINE_BYTES-1:0] lane_sel(
		input mem_pkg::mem_size sz,
		input logic [LANE_BITS-1:0] ofs
	);
		logic [LINE_BYTES-1:0] base;
		case (sz)
			mem_pkg::SZ_BYTE:  base = 16'h0001;
			mem_pkg::SZ_WYDE:  base = 16'h0003;
			mem_pkg::SZ_TETRA: base = 16'h000F;
			default:           base = 16'h00FF;
		endcase
		return base << ofs;
	endfunction

	// Mask that keeps the low bytes belonging to an access of the given size
	function automatic logic [63:0] size_mask(input mem_pkg::mem_size sz);
		logic [63:0] m;
		case (sz)
			mem_pkg::SZ_BYTE:  m = 64'h0000_0000_0000_00FF;
			mem_pkg::SZ_WYDE:  m = 64'h0000_0000_0000_FFFF;
			mem_pkg::SZ_TETRA: m = 64'h0000_0000_FFFF_FFFF;
			default:           m = 64'hFFFF_FFFF_FFFF_FFFF;
		endcase
		return m;
	endfunction

endpackage

`default_nettype wire

//--- mem_req_queue/req_store.sv
`default_nettype none

// In-order entry store built as a shift register
// The oldest entry always sits at index 0, and a pop moves every entry down
// by one place. A push and a pop may happen in the same cycle
module req_store #(
	parameter int QDEP = 8
) (
	input  wire logic                           clk,
	input  wire logic                           rst,
	input  wire logic                           push,
	input  wire mem_pkg::mem_request            push_req,
	input  wire logic                           pop,
	output mem_pkg::mem_request [QDEP-1:0]      entries,
	output logic [QDEP-1:0]                     entry_valid,
	output logic [$clog2(QDEP+1)-1:0]           count
);
	localparam int CWID = $clog2(QDEP + 1);

	// Slot the incoming request lands in
	logic [CWID-1:0] wr_idx;

	// ==============================
	// Write index
	// ==============================

	// Without a pop the new entry goes right after the youngest one
	// With a pop everything shifts down, so the free slot is one lower
	// The arbiter only pops a non-empty queue, so count is at least one then
	always_comb begin
		if (pop) begin
			wr_idx = count - 1'b1;
		end else begin
			wr_idx = count;
		end
	end

	// ==============================
	// Entry payload
	// ==============================

	// The shift and the write share one block so that the write to the
	// slot freed by the shift takes effect over the shifted value
	always_ff @(posedge clk) begin
		if (pop) begin
			for (int i = 0; i < QDEP - 1; i++) begin
				entries[i] <= entries[i + 1];
			end
		end
		if (push) begin
			entries[wr_idx] <= push_req;
		end
	end

	// ==============================
	// Occupancy
	// ==============================

	// Count moves by plus one, minus one or not at all
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			count <= count + CWID'(push) - CWID'(pop);
		end
	end

	// Entries below count are live, the rest are stale copies
	// left behind by the shifting
	always_comb begin
		for (int i = 0; i < QDEP; i++) begin
			entry_valid[i] = (count > CWID'(i));
		end
	end

endmodule

`default_nettype wire

//--- mem_req_queue/load_forward.sv
`default_nettype none

// Store-to-load forwarding for one request port
// A load whose bytes all come from a single queued store is answered from
// that store without going to memory. With several covering stores the
// youngest one provides the data
module load_forward #(
	parameter int AWID = 32,
	parameter int QDEP = 8
) (
	input  wire mem_pkg::mem_request              req,
	input  wire mem_pkg::mem_request [QDEP-1:0]   entries,
	input  wire logic [QDEP-1:0]                  entry_valid,
	output mem_pkg::mem_request                   fwd_req,
	output logic                                  found
);
	import mem_pkg::*;
	import lane_pkg::*;

	logic                  is_load;
	logic [LINE_BYTES-1:0] ld_sel;
	logic [QDEP-1:0]       hit;
	logic [63:0]           st_dat;
	logic [LANE_BITS-1:0]  st_ofs;
	logic [LANE_BITS-1:0]  ofs_diff;
	logic [63:0]           shifted;
	logic [63:0]           ld_mask;
	logic [63:0]           masked;
	logic                  sign;

	// Only the two load flavours are ever forwarded
	assign is_load = (req.func == MR_LOAD) || (req.func == MR_LOADZ);
	assign ld_sel  = lane_sel(req.sz, req.adr[LANE_BITS-1:0]);

	// ==============================
	// Match search
	// ==============================

	// A store matches when it is live, sits in the same line and its bytes
	// include every byte of the load
	// Partial overlaps fall out here and the load is simply queued
	always_comb begin
		logic [LINE_BYTES-1:0] st_sel;
		for (int i = 0; i < QDEP; i++) begin
			st_sel = lane_sel(entries[i].sz, entries[i].adr[LANE_BITS-1:0]);
			hit[i] = entry_valid[i]
				&& (entries[i].func == MR_STORE)
				&& (entries[i].adr[AWID-1:LANE_BITS] == req.adr[AWID-1:LANE_BITS])
				&& ((ld_sel & ~st_sel) == '0);
		end
	end

	// Walk from oldest to youngest so the last hit seen is the youngest
	always_comb begin
		st_dat = '0;
		st_ofs = '0;
		for (int i = 0; i < QDEP; i++) begin
			if (hit[i]) begin
				st_dat = entries[i].dat;
				st_ofs = entries[i].adr[LANE_BITS-1:0];
			end
		end
	end

	assign found = is_load && (|hit);

	// ==============================
	// Align, mask and extend
	// ==============================

	// A covering store never starts after the load, so the difference of the
	// offsets is the number of bytes to drop from the store data
	assign ofs_diff = req.adr[LANE_BITS-1:0] - st_ofs;
	assign shifted  = st_dat >> {ofs_diff, 3'b000};
	assign ld_mask  = size_mask(req.sz);
	assign masked   = shifted & ld_mask;

	// Sign comes from the top bit of the highest loaded byte
	always_comb begin
		case (req.sz)
			SZ_BYTE:  sign = shifted[7];
			SZ_WYDE:  sign = shifted[15];
			SZ_TETRA: sign = shifted[31];
			default:  sign = shifted[63];
		endcase
	end

	// The load comes back unchanged apart from its data field
	always_comb begin
		fwd_req = req;
		if (found) begin
			if (req.func == MR_LOAD && sign) begin
				fwd_req.dat = masked | ~ld_mask;
			end else begin
				fwd_req.dat = masked;
			end
		end
	end

endmodule

`default_nettype wire

//--- mem_req_queue/enq_arbiter.sv
`default_nettype none

// Enqueue arbiter of the request queue
// It decides which port is taken in a cycle, drives the push and the pop of
// the entry store, filters a repeated tid and produces the one-cycle acks
module enq_arbiter #(
	parameter int QDEP = 8
) (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire logic                      wr0,
	input  wire mem_pkg::mem_request       i0,
	input  wire logic                      found0,
	input  wire logic                      wr1,
	input  wire mem_pkg::mem_request       i1,
	input  wire logic                      found1,
	input  wire logic [$clog2(QDEP+1)-1:0] count,
	input  wire logic                      rd,
	output logic                           wr_ack0,
	output logic                           wr_ack1,
	output logic                           push,
	output mem_pkg::mem_request            push_req,
	output logic                           pop
);
	import mem_pkg::*;

	logic       req0, req1;
	logic       want0, want1;
	logic       grant0, grant1;
	logic       taken0, taken1;
	logic       room;
	logic [7:0] last_tid;

	// ==============================
	// Pop and room
	// ==============================

	// A read of an empty queue does nothing
	assign pop  = rd && (count != '0);
	// A full queue still accepts a push when the head leaves in the same cycle
	assign room = (count < QDEP) || pop;

	// ==============================
	// Port selection
	// ==============================

	// A port whose ack is still high was taken last cycle and its requester
	// has not yet moved on, so it is held off for this cycle
	assign req0 = wr0 && !wr_ack0;
	assign req1 = wr1 && !wr_ack1;

	// Requests that cannot be forwarded need a slot in the queue
	assign want0 = req0 && !found0;
	assign want1 = req1 && !found1;

	// Port 0 always wins the push, port 1 waits for a cycle where port 0
	// does not want the queue
	assign grant0 = want0 && room;
	assign grant1 = want1 && room && !want0;

	// Forwarding needs no slot, so both ports may be taken at once
	assign taken0 = req0 && (found0 || grant0);
	assign taken1 = req1 && (found1 || grant1);

	// ==============================
	// Push and repeated tids
	// ==============================

	assign push_req = grant0 ? i0 : i1;
	// A repeated tid is acknowledged but never written a second time
	assign push = (grant0 || grant1) && (push_req.tid != last_tid);

	// ==============================
	// Acks and last tid
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ack0  <= 1'b0;
			wr_ack1  <= 1'b0;
			last_tid <= TID_NONE;
		end else begin
			// Each ack is high for exactly the cycle after the port was taken
			wr_ack0 <= taken0;
			wr_ack1 <= taken1;
			if (push) begin
				last_tid <= push_req.tid;
			end
		end
	end

endmodule

`default_nettype wire

//--- mem_req_queue/mem_req_queue.sv
`default_nettype none

// Load/store request queue of the memory stage
// Two request ports feed an in-order queue, and loads covered by a queued
// store are answered straight away by forwarding
module mem_req_queue #(
	parameter int AWID = 32,
	parameter int QDEP = 8
) (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                wr0,
	input  wire mem_pkg::mem_request i0,
	output logic                     wr_ack0,
	output logic                     found0,
	output mem_pkg::mem_request      ldo0,
	input  wire logic                wr1,
	input  wire mem_pkg::mem_request i1,
	output logic                     wr_ack1,
	output logic                     found1,
	output mem_pkg::mem_request      ldo1,
	input  wire logic                rd,
	output mem_pkg::mem_request      o,
	output logic                     valid,
	output logic                     empty
);
	import mem_pkg::*;

	localparam int CWID = $clog2(QDEP + 1);

	// Queue contents as seen by both forwarders
	mem_request [QDEP-1:0] entries;
	logic [QDEP-1:0]       entry_valid;
	logic [CWID-1:0]       count;

	// Arbiter to store
	logic       push;
	logic       pop;
	mem_request push_req;

	// ==============================
	// Entry store
	// ==============================

	req_store #(.QDEP(QDEP)) store (
		.clk(clk), .rst(rst),
		.push(push), .push_req(push_req), .pop(pop),
		.entries(entries), .entry_valid(entry_valid), .count(count)
	);

	// ==============================
	// Store-to-load forwarding
	// ==============================

	// One forwarder per port, both searching the same entries
	load_forward #(.AWID(AWID), .QDEP(QDEP)) fwd0 (
		.req(i0), .entries(entries), .entry_valid(entry_valid),
		.fwd_req(ldo0), .found(found0)
	);

	load_forward #(.AWID(AWID), .QDEP(QDEP)) fwd1 (
		.req(i1), .entries(entries), .entry_valid(entry_valid),
		.fwd_req(ldo1), .found(found1)
	);

	// ==============================
	// Enqueue arbitration
	// ==============================

	enq_arbiter #(.QDEP(QDEP)) arb (
		.clk(clk), .rst(rst),
		.wr0(wr0), .i0(i0), .found0(found0),
		.wr1(wr1), .i1(i1), .found1(found1),
		.count(count), .rd(rd),
		.wr_ack0(wr_ack0), .wr_ack1(wr_ack1),
		.push(push), .push_req(push_req), .pop(pop)
	);

	// The memory side always looks at the oldest entry
	assign o     = entries[0];
	assign valid = entry_valid[0];
	assign empty = ~entry_valid[0];

endmodule

`default_nettype wire

//--- tests/mem_req_queue_chk.sv
`default_nettype none

// Checker bound to the request queue
// It keeps its own model of the queue, built from the request ports, and
// compares the DUT outputs against it every cycle
module mem_req_queue_chk #(
	parameter int QDEP = 8
) (
	input wire logic                        clk,
	input wire logic                        rst,
	input wire logic                        wr0,
	input wire mem_pkg::mem_request         i0,
	input wire logic                        wr_ack0,
	input wire logic                        found0,
	input wire mem_pkg::mem_request         ldo0,
	input wire logic                        wr1,
	input wire mem_pkg::mem_request         i1,
	input wire logic                        wr_ack1,
	input wire logic                        found1,
	input wire mem_pkg::mem_request         ldo1,
	input wire logic                        rd,
	input wire mem_pkg::mem_request         o,
	input wire logic                        valid,
	input wire logic                        empty,
	input wire logic [$clog2(QDEP+1)-1:0]   count
);
	timeunit 1ns;
	timeprecision 1ps;
	import mem_pkg::*;

	// Shadow queue, oldest entry first
	mem_request sh [QDEP];
	int         sh_n;
	logic [7:0] last_m;
	logic       ack0_m;
	logic       ack1_m;
	// Expected forward results of both ports
	logic        ef0;
	logic        ef1;
	logic [63:0] ed0;
	logic [63:0] ed1;
	// Expected arbitration of the current cycle
	logic       r0, r1, w0, w1, g0, g1, t0, t1;
	logic       pop_m, room, push_m;
	mem_request preq;
	int         fail_cnt = 0;

	// ==============================
	// Forwarding model
	// ==============================

	// Byte-wise forwarding model that picks the load's bytes one by one from the
	// youngest store whose byte range holds the whole load, and extends them
	function automatic logic [64:0] fwd_model(input mem_request ld);
		int          nb, lo, sb, so, d;
		logic        hit;
		logic        sign;
		logic [63:0] st;
		logic [63:0] v;
		hit = 1'b0;
		st = '0;
		d = 0;
		v = '0;
		nb = 1 << ld.sz;
		lo = ld.adr[3:0];
		for (int i = 0; i < QDEP; i++) begin
			if (i < sh_n && sh[i].func == MR_STORE && sh[i].adr[31:4] == ld.adr[31:4]) begin
				sb = 1 << sh[i].sz;
				so = sh[i].adr[3:0];
				if (so <= lo && lo + nb <= so + sb) begin
					hit = 1'b1;
					st = sh[i].dat;
					d = lo - so;
				end
			end
		end
		for (int k = 0; k < nb; k++) begin
			v[k * 8 +: 8] = st[(d + k) * 8 +: 8];
		end
		sign = v[nb * 8 - 1];
		// Bytes above the load size carry the sign for MR_LOAD only
		for (int k = nb; k < 8; k++) begin
			v[k * 8 +: 8] = (ld.func == MR_LOAD && sign) ? 8'hFF : 8'h00;
		end
		return {hit && ld.func != MR_STORE, v};
	endfunction

	// ==============================
	// Arbitration model
	// ==============================

	always_comb begin
		{ef0, ed0} = fwd_model(i0);
		{ef1, ed1} = fwd_model(i1);
		// A port with its ack still high is not taken again
		r0 = wr0 && !ack0_m;
		r1 = wr1 && !ack1_m;
		w0 = r0 && !ef0;
		w1 = r1 && !ef1;
		pop_m = rd && (sh_n > 0);
		room = (sh_n < QDEP) || pop_m;
		g0 = w0 && room;
		g1 = w1 && room && !w0;
		t0 = r0 && (ef0 || g0);
		t1 = r1 && (ef1 || g1);
		preq = g0 ? i0 : i1;
		push_m = (g0 || g1) && (preq.tid != last_m);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sh_n <= 0;
			ack0_m <= 1'b0;
			ack1_m <= 1'b0;
			last_m <= TID_NONE;
		end else begin
			ack0_m <= t0;
			ack1_m <= t1;
			if (pop_m) begin
				for (int i = 0; i < QDEP - 1; i++) begin
					sh[i] <= sh[i + 1];
				end
			end
			if (push_m) begin
				sh[pop_m ? sh_n - 1 : sh_n] <= preq;
				last_m <= preq.tid;
			end
			sh_n <= sh_n + int'(push_m) - int'(pop_m);
		end
	end

	// ==============================
	// Assertions
	// ==============================

	a_reset: assert property (@(posedge clk) disable iff (rst)
		$fell(rst) |-> !valid && empty && !wr_ack0 && !wr_ack1)
	else begin
		fail_cnt++;
		$error("%0t: outputs not idle after reset", $time);
	end

	// Occupancy, valid and empty all follow the shadow
	a_occupancy: assert property (@(posedge clk) disable iff (rst)
		count == sh_n && valid == (sh_n != 0) && empty == (sh_n == 0))
	else begin
		fail_cnt++;
		$error("%0t: count %0d but shadow holds %0d", $time, $sampled(count), $sampled(sh_n));
	end

	a_head: assert property (@(posedge clk) disable iff (rst) rd && valid |-> o == sh[0])
	else begin
		fail_cnt++;
		$error("%0t: head tid %0d, expected %0d", $time, $sampled(o.tid), $sampled(sh[0].tid));
	end

	// A forwarded load keeps its own fields and only gets new data
	a_fwd0: assert property (@(posedge clk) disable iff (rst)
		found0 == ef0 && (!found0 || ldo0 == {i0.tid, i0.func, i0.sz, i0.adr, ed0}))
	else begin
		fail_cnt++;
		$error("%0t: port 0 forward %h, expected %h", $time, $sampled(ldo0.dat), $sampled(ed0));
	end

	a_fwd1: assert property (@(posedge clk) disable iff (rst)
		found1 == ef1 && (!found1 || ldo1 == {i1.tid, i1.func, i1.sz, i1.adr, ed1}))
	else begin
		fail_cnt++;
		$error("%0t: port 1 forward %h, expected %h", $time, $sampled(ldo1.dat), $sampled(ed1));
	end

	// One-cycle acks, in port priority and only with room or a forward
	a_acks: assert property (@(posedge clk) disable iff (rst)
		wr_ack0 == ack0_m && wr_ack1 == ack1_m)
	else begin
		fail_cnt++;
		$error("%0t: acks %b%b, expected %b%b", $time, $sampled(wr_ack0), $sampled(wr_ack1),
			$sampled(ack0_m), $sampled(ack1_m));
	end

endmodule

`default_nettype wire

//--- tests/mem_req_queue_tb.sv
`default_nettype none

// Testbench of the load/store request queue
// Directed requests first, then random traffic on both ports
module mem_req_queue_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import mem_pkg::*;

	localparam int QDEP  = 8;
	localparam int NRAND = 200;
	localparam int NDIR  = 21;
	// Watchdog limit in clock cycles
	localparam int LIMIT = (NDIR + NRAND) * 4 + QDEP * 4 + 100;

	logic       clk;
	logic       rst;
	logic       wr0;
	logic       wr1;
	logic       rd;
	logic       wr_ack0;
	logic       wr_ack1;
	logic       found0;
	logic       found1;
	logic       valid;
	logic       empty;
	mem_request i0;
	mem_request i1;
	mem_request ldo0;
	mem_request ldo1;
	mem_request o;
	int         seed = 64248;
	int         timeouts = 0;
	logic       rd_rand = 1'b0;

	mem_req_queue #(.AWID(32), .QDEP(QDEP)) UUT (.*);

	bind mem_req_queue mem_req_queue_chk #(.QDEP(QDEP)) chk (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==============================
	// Request helpers
	// ==============================

	function automatic mem_request make_req(input logic [7:0] tid, input mem_func func,
		input mem_size sz, input logic [31:0] adr, input logic [63:0] dat);
		return '{tid: tid, func: func, sz: sz, adr: adr, dat: dat};
	endfunction

	// Random request inside two neighbouring lines so stores and loads meet
	function automatic mem_request rand_req();
		logic [31:0] r;
		mem_size     sz;
		logic [3:0]  ofs;
		r = $random(seed);
		sz = mem_size'(r[1:0]);
		ofs = r[7:4] & ~((4'd1 << sz) - 4'd1);
		return make_req(r[15:8], mem_func'(r[17:16] % 3), sz, 32'h400 + {r[18], ofs},
			{$random(seed), $random(seed)});
	endfunction

	// Holds a request on one port until its ack shows up, called on a falling edge
	task automatic issue(input int port, input mem_request r);
		if (port == 0) begin
			wr0 = 1'b1;
			i0 = r;
		end else begin
			wr1 = 1'b1;
			i1 = r;
		end
		do @(negedge clk); while (!(port == 0 ? wr_ack0 : wr_ack1));
		if (port == 0) begin
			wr0 = 1'b0;
		end else begin
			wr1 = 1'b0;
		end
	endtask

	task automatic drain();
		while (!empty) begin
			rd = 1'b1;
			@(negedge clk);
		end
		rd = 1'b0;
	endtask

	task automatic finish_run();
		$display("Assertion failures: %0d, timeouts: %0d", UUT.chk.fail_cnt, timeouts);
		if (UUT.chk.fail_cnt == 0 && timeouts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	// Random reads while the random phase runs
	always @(negedge clk) begin
		if (rd_rand) begin
			rd = 1'($random(seed));
		end
	end

	// ==============================
	// Stimulus
	// ==============================

	initial begin
		rst = 1'b1;
		wr0 = 1'b0;
		wr1 = 1'b0;
		rd = 1'b0;
		i0 = '0;
		i1 = '0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		repeat (3) @(negedge clk);
		// A store, then loads it covers, then a younger overlapping store
		issue(0, make_req(8'd1, MR_STORE, SZ_OCTA, 32'h100, 64'h8877_6655_4433_2211));
		issue(0, make_req(8'd2, MR_LOAD, SZ_WYDE, 32'h106, '0));
		issue(1, make_req(8'd3, MR_LOADZ, SZ_BYTE, 32'h107, '0));
		issue(1, make_req(8'd4, MR_STORE, SZ_TETRA, 32'h104, 64'hF0E0_D0C0));
		issue(0, make_req(8'd5, MR_LOAD, SZ_TETRA, 32'h104, '0));
		issue(0, make_req(8'd6, MR_LOAD, SZ_BYTE, 32'h101, '0));
		// Load only partly inside a store goes into the queue
		issue(0, make_req(8'd7, MR_STORE, SZ_WYDE, 32'h110, 64'hBEEF));
		issue(1, make_req(8'd8, MR_LOADZ, SZ_TETRA, 32'h110, '0));
		// Same tid twice, the second is acked but not stored
		issue(0, make_req(8'd9, MR_LOAD, SZ_OCTA, 32'h200, '0));
		issue(1, make_req(8'd9, MR_LOAD, SZ_OCTA, 32'h200, '0));
		// Both ports want a push in the same cycle
		fork
			issue(0, make_req(8'd10, MR_LOAD, SZ_OCTA, 32'h300, '0));
			issue(1, make_req(8'd11, MR_LOADZ, SZ_OCTA, 32'h308, '0));
		join
		drain();

		// ==============================
		// Full queue and back-pressure
		// ==============================

		for (int k = 0; k < QDEP; k++) begin
			issue(k % 2, make_req(8'(20 + k), MR_LOAD, SZ_OCTA, 32'h500 + 8 * k, '0));
		end
		// The extra request waits until a read frees the head
		fork
			issue(0, make_req(8'd40, MR_LOADZ, SZ_OCTA, 32'h580, '0));
			begin
				repeat (4) @(negedge clk);
				rd = 1'b1;
				@(negedge clk);
				rd = 1'b0;
			end
		join
		drain();

		// Random traffic on both ports at once
		rd_rand = 1'b1;
		repeat (NRAND / 2) begin
			fork
				issue(0, rand_req());
				issue(1, rand_req());
			join
		end
		rd_rand = 1'b0;
		rd = 1'b0;
		drain();
		repeat (4) @(negedge clk);
		finish_run();
	end

	// Watchdog
	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", LIMIT);
		timeouts++;
		finish_run();
	end

endmodule

`default_nettype wire

//--- mem_req_queue.f
common/mem_pkg.sv
common/lane_pkg.sv
mem_req_queue/req_store.sv
mem_req_queue/load_forward.sv
mem_req_queue/enq_arbiter.sv
mem_req_queue/mem_req_queue.sv
tests/mem_req_queue_chk.sv
tests/mem_req_queue_tb.sv
